//--- hdl/sdram_pkg.sv
package sdram_pkg;

  typedef logic [15:0] data_t;

  // A set bit keeps the stored byte.
  typedef logic [1:0] mask_t;

  // Encoded as the {ras, cas, we} pin pattern, all active low.
  typedef enum logic [2:0] {
    cmd_load_mode  = 3'b000,
    cmd_active     = 3'b011,
    cmd_read       = 3'b101,
    cmd_write      = 3'b100,
    cmd_burst_stop = 3'b110,
    cmd_nop        = 3'b111
  } sdram_cmd_t;

  typedef enum logic [2:0] {
    st_init_wait,
    st_load_mode,
    st_idle,
    st_activate,
    st_trcd,
    st_read,
    st_write,
    st_burst
  } ctrl_state_t;

  // Burst length field of the mode register.
  typedef enum logic [2:0] {
    bl_1 = 3'd0,
    bl_2 = 3'd1,
    bl_4 = 3'd2,
    bl_8 = 3'd3
  } burst_code_t;

  function automatic int unsigned beat_count(burst_code_t code);
    return 1 << code;
  endfunction

endpackage

//--- hdl/sdram_timer.sv
module sdram_timer (
  input  logic       clk,
  input  logic       reset,
  input  logic       load,
  input  logic [7:0] value,
  output logic       done
);

  logic [7:0] count;

  // Done marks the cycle the count lands on zero.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 8'd0;
      done  <= 1'b0;
    end else if (load) begin
      count <= value;
      done  <= (value == 8'd0);
    end else if (count != 8'd0) begin
      count <= count - 8'd1;
      done  <= (count == 8'd1);
    end else begin
      done <= 1'b0;
    end
  end

endmodule

//--- hdl/sdram_wr_path.sv
module sdram_wr_path (
  input  logic             clk,
  input  logic             reset,
  input  logic             beat_wr,
  input  sdram_pkg::data_t wdata,
  input  sdram_pkg::mask_t wmask,
  inout  sdram_pkg::data_t dq,
  output sdram_pkg::mask_t dqm
);

  sdram_pkg::data_t dout;
  sdram_pkg::mask_t mask_q;
  logic             oe;

  always_ff @(posedge clk) begin
    if (reset) begin
      oe <= 1'b0;
    end else begin
      oe <= beat_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_wr) begin
      dout   <= wdata;
      mask_q <= wmask;
    end
  end

  // Bus released and all bytes masked between beats.
  assign dq  = oe ? dout : 'z;
  assign dqm = oe ? mask_q : 2'b11;

endmodule

//--- hdl/sdram_rd_capture.sv
module sdram_rd_capture #(
  parameter int cas_latency = 2,
  parameter sdram_pkg::burst_code_t burst_code = sdram_pkg::bl_4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             read_start,
  input  sdram_pkg::data_t dq,
  output sdram_pkg::data_t rdata,
  output logic             rdata_valid
);

  localparam int unsigned beats = sdram_pkg::beat_count(burst_code);

  logic [cas_latency-1:0] lat_sr;
  logic [3:0]             beats_left;
  logic                   capture;

  // Top tap lines up with the first beat on dq.
  assign capture = lat_sr[cas_latency-1] || beats_left != 4'd0;

  always_ff @(posedge clk) begin
    if (reset) begin
      lat_sr      <= '0;
      beats_left  <= 4'd0;
      rdata_valid <= 1'b0;
    end else begin
      lat_sr      <= {lat_sr[cas_latency-2:0], read_start};
      rdata_valid <= capture;
      if (lat_sr[cas_latency-1]) begin
        beats_left <= 4'(beats - 1);
      end else if (beats_left != 4'd0) begin
        beats_left <= beats_left - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rdata <= dq;
    end
  end

endmodule

//--- hdl/sdram_model.sv
module sdram_model #(
  parameter int row_bits = 4,
  parameter int col_bits = 5
) (
  input  logic               clk,
  input  logic               cke,
  input  logic               cs,
  input  logic               ras,
  input  logic               cas,
  input  logic               we,
  input  logic [12:0]        a,
  input  logic [1:0]         ba,
  input  sdram_pkg::mask_t   dqm,
  inout  sdram_pkg::data_t   dq
);

  localparam int addr_bits = 2 + row_bits + col_bits;

  sdram_pkg::data_t       mem [2**addr_bits];
  sdram_pkg::sdram_cmd_t  cmd;
  sdram_pkg::burst_code_t burst_len;
  logic [2:0]             cas_lat;
  logic                   sel;
  logic                   do_load;
  logic                   do_active;
  logic                   do_read;
  logic                   do_write;
  logic                   do_stop;
  logic [1:0]             bank_q;
  logic [row_bits-1:0]    row_q;
  logic [col_bits-1:0]    rd_col;
  logic [col_bits-1:0]    wr_col;
  logic [col_bits-1:0]    wr_col_now;
  logic [3:0]             wr_left;
  logic                   wr_beat;
  logic [addr_bits-1:0]   wr_addr;
  logic [addr_bits-1:0]   rd_addr;
  sdram_pkg::data_t       stored;
  sdram_pkg::data_t       merged;
  sdram_pkg::data_t       rd_word;
  sdram_pkg::data_t       rd_pipe1;
  sdram_pkg::data_t       rd_pipe2;
  sdram_pkg::data_t       dq_out;
  logic                   dq_oe;

  assign cmd       = sdram_pkg::sdram_cmd_t'({ras, cas, we});
  assign sel       = cke && !cs;
  assign do_load   = sel && cmd == sdram_pkg::cmd_load_mode;
  assign do_active = sel && cmd == sdram_pkg::cmd_active;
  assign do_read   = sel && cmd == sdram_pkg::cmd_read;
  assign do_write  = sel && cmd == sdram_pkg::cmd_write;
  assign do_stop   = sel && cmd == sdram_pkg::cmd_burst_stop;

  always_ff @(posedge clk) begin
    if (do_load) begin
      burst_len <= sdram_pkg::burst_code_t'(a[2:0]);
      cas_lat   <= a[6:4];
    end
    if (do_active) begin
      bank_q <= ba;
      row_q  <= a[row_bits-1:0];
    end
  end

  // Write burst. Beat 0 goes to the column on the pins.
  assign wr_col_now = do_write ? a[col_bits-1:0] : wr_col;
  assign wr_beat    = do_write || (wr_left != 4'd0 && !do_stop);
  assign wr_addr    = {bank_q, row_q, wr_col_now};
  assign stored     = mem[wr_addr];
  assign merged     = {dqm[1] ? stored[15:8] : dq[15:8],
                       dqm[0] ? stored[7:0] : dq[7:0]};

  always_ff @(posedge clk) begin
    wr_col <= wr_col_now + 1'b1;
    // Mode load during init also clears the burst counter.
    if (do_load || do_stop) begin
      wr_left <= 4'd0;
    end else if (do_write) begin
      wr_left <= 4'(sdram_pkg::beat_count(burst_len) - 1);
    end else if (wr_left != 4'd0) begin
      wr_left <= wr_left - 4'd1;
    end
    if (wr_beat) begin
      mem[wr_addr] <= merged;
    end
  end

  // Read column runs on freely after the command.
  always_ff @(posedge clk) begin
    if (do_read) begin
      rd_col <= a[col_bits-1:0];
    end else begin
      rd_col <= rd_col + 1'b1;
    end
    rd_pipe1 <= rd_word;
    rd_pipe2 <= rd_pipe1;
  end

  assign rd_addr = {bank_q, row_q, rd_col};
  assign rd_word = mem[rd_addr];
  assign dq_out  = (cas_lat == 3'd3) ? rd_pipe2 : rd_pipe1;

  assign dq_oe = !(do_write || wr_left != 4'd0);
  assign dq    = dq_oe ? dq_out : 'z;

endmodule

//--- hdl/sdram_cmd_fsm.sv
module sdram_cmd_fsm #(
  parameter sdram_pkg::burst_code_t burst_code = sdram_pkg::bl_4,
  parameter int cas_latency = 2,
  parameter int trcd_cycles = 2,
  parameter int init_cycles = 20
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic                  req_write,
  input  logic [1:0]            req_bank,
  input  logic [12:0]           req_row,
  input  logic [8:0]            req_col,
  input  logic                  timer_done,
  output logic                  ready,
  output logic                  busy,
  output logic                  wdata_take,
  output sdram_pkg::sdram_cmd_t cmd,
  output logic [12:0]           addr,
  output logic [1:0]            ba,
  output logic                  cs,
  output logic                  timer_load,
  output logic [7:0]            timer_value,
  output logic                  beat_wr,
  output logic                  read_start
);

  localparam int unsigned beats = sdram_pkg::beat_count(burst_code);
  localparam logic [7:0] init_wait = 8'(init_cycles);
  // Needs trcd_cycles of at least 2.
  localparam logic [7:0] trcd_wait = 8'(trcd_cycles - 1);
  localparam logic [7:0] wr_wait = 8'(beats - 1);
  localparam logic [7:0] rd_wait = 8'(cas_latency + beats + 1);
  localparam logic [12:0] mode_word = {6'd0, 3'(cas_latency), 1'b0, burst_code};

  sdram_pkg::ctrl_state_t state;
  logic                   init_start;
  logic                   write_q;
  logic [8:0]             col_q;
  logic                   take;

  assign wdata_take = take;
  assign beat_wr    = take;

  always_comb begin
    timer_load  = 1'b0;
    timer_value = init_wait;
    if (init_start) begin
      timer_load = 1'b1;
    end else if (state == sdram_pkg::st_idle && req) begin
      timer_load  = 1'b1;
      timer_value = trcd_wait;
    end else if (state == sdram_pkg::st_trcd && timer_done) begin
      timer_load  = 1'b1;
      timer_value = write_q ? wr_wait : rd_wait;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= sdram_pkg::st_init_wait;
      init_start <= 1'b1;
      ready      <= 1'b0;
      busy       <= 1'b0;
      take       <= 1'b0;
      read_start <= 1'b0;
      cmd        <= sdram_pkg::cmd_nop;
      cs         <= 1'b1;
    end else begin
      init_start <= 1'b0;
      cmd        <= sdram_pkg::cmd_nop;
      cs         <= 1'b1;
      read_start <= 1'b0;
      case (state)
        sdram_pkg::st_init_wait: begin
          if (timer_done) begin
            cmd   <= sdram_pkg::cmd_load_mode;
            cs    <= 1'b0;
            addr  <= mode_word;
            state <= sdram_pkg::st_load_mode;
          end
        end
        sdram_pkg::st_load_mode: begin
          ready <= 1'b1;
          state <= sdram_pkg::st_idle;
        end
        sdram_pkg::st_idle: begin
          if (req) begin
            busy    <= 1'b1;
            cmd     <= sdram_pkg::cmd_active;
            cs      <= 1'b0;
            addr    <= req_row;
            ba      <= req_bank;
            write_q <= req_write;
            col_q   <= req_col;
            state   <= sdram_pkg::st_activate;
          end
        end
        sdram_pkg::st_activate: state <= sdram_pkg::st_trcd;
        sdram_pkg::st_trcd: begin
          if (timer_done) begin
            // First take leads the write command by one cycle.
            take  <= write_q;
            state <= write_q ? sdram_pkg::st_write : sdram_pkg::st_read;
          end
        end
        sdram_pkg::st_read: begin
          cmd        <= sdram_pkg::cmd_read;
          cs         <= 1'b0;
          addr       <= {4'd0, col_q};
          read_start <= 1'b1;
          state      <= sdram_pkg::st_burst;
        end
        sdram_pkg::st_write: begin
          cmd   <= sdram_pkg::cmd_write;
          cs    <= 1'b0;
          addr  <= {4'd0, col_q};
          state <= sdram_pkg::st_burst;
          if (timer_done) begin
            take <= 1'b0;
          end
        end
        sdram_pkg::st_burst: begin
          if (timer_done) begin
            take <= 1'b0;
          end
          // Writes end a cycle after the last take.
          if (write_q ? !take : timer_done) begin
            busy  <= 1'b0;
            state <= sdram_pkg::st_idle;
          end
        end
        default: state <= sdram_pkg::st_idle;
      endcase
    end
  end

endmodule

//--- hdl/sdram_subsys.sv
module sdram_subsys #(
  parameter sdram_pkg::burst_code_t burst_code = sdram_pkg::bl_4,
  parameter int cas_latency = 2,
  parameter int trcd_cycles = 2,
  parameter int init_cycles = 20,
  parameter int row_bits = 4,
  parameter int col_bits = 5
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             req,
  input  logic             req_write,
  input  logic [1:0]       req_bank,
  input  logic [12:0]      req_row,
  input  logic [8:0]       req_col,
  input  sdram_pkg::data_t wdata,
  input  sdram_pkg::mask_t wmask,
  output logic             ready,
  output logic             busy,
  output logic             wdata_take,
  output sdram_pkg::data_t rdata,
  output logic             rdata_valid
);

  sdram_pkg::sdram_cmd_t cmd;
  logic [12:0]           addr;
  logic [1:0]            ba;
  logic                  cs;
  logic                  ras;
  logic                  cas;
  logic                  we;
  logic                  cke;
  logic                  timer_load;
  logic [7:0]            timer_value;
  logic                  timer_done;
  logic                  beat_wr;
  logic                  read_start;
  sdram_pkg::mask_t      dqm;
  tri sdram_pkg::data_t  dq;

  assign {ras, cas, we} = cmd;
  assign cke = 1'b1;

  sdram_cmd_fsm #(
    .burst_code  (burst_code),
    .cas_latency (cas_latency),
    .trcd_cycles (trcd_cycles),
    .init_cycles (init_cycles)
  ) u_fsm (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_write   (req_write),
    .req_bank    (req_bank),
    .req_row     (req_row),
    .req_col     (req_col),
    .timer_done  (timer_done),
    .ready       (ready),
    .busy        (busy),
    .wdata_take  (wdata_take),
    .cmd         (cmd),
    .addr        (addr),
    .ba          (ba),
    .cs          (cs),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .beat_wr     (beat_wr),
    .read_start  (read_start)
  );

  sdram_timer u_timer (
    .clk   (clk),
    .reset (reset),
    .load  (timer_load),
    .value (timer_value),
    .done  (timer_done)
  );

  sdram_wr_path u_wr_path (
    .clk     (clk),
    .reset   (reset),
    .beat_wr (beat_wr),
    .wdata   (wdata),
    .wmask   (wmask),
    .dq      (dq),
    .dqm     (dqm)
  );

  sdram_rd_capture #(
    .cas_latency (cas_latency),
    .burst_code  (burst_code)
  ) u_rd_capture (
    .clk         (clk),
    .reset       (reset),
    .read_start  (read_start),
    .dq          (dq),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  sdram_model #(
    .row_bits (row_bits),
    .col_bits (col_bits)
  ) u_model (
    .clk (clk),
    .cke (cke),
    .cs  (cs),
    .ras (ras),
    .cas (cas),
    .we  (we),
    .a   (addr),
    .ba  (ba),
    .dqm (dqm),
    .dq  (dq)
  );

endmodule

//--- sim/tb_sdram_subsys.sv
module tb_sdram_subsys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam sdram_pkg::burst_code_t burst_code = sdram_pkg::bl_4;
  localparam int cas_latency = 2;
  localparam int trcd_cycles = 2;
  localparam int init_cycles = 20;
  localparam int row_bits = 4;
  localparam int col_bits = 5;
  localparam int reset_cycles = 16;
  localparam int max_entries = 24;
  localparam int beats = sdram_pkg::beat_count(burst_code);
  localparam int entry_cycles = 4 + trcd_cycles + cas_latency + 2 * beats;

  logic             clk;
  logic             reset;
  logic             req;
  logic             req_write;
  logic [1:0]       req_bank;
  logic [12:0]      req_row;
  logic [8:0]       req_col;
  sdram_pkg::data_t wdata;
  sdram_pkg::mask_t wmask;
  logic             ready;
  logic             busy;
  logic             wdata_take;
  sdram_pkg::data_t rdata;
  logic             rdata_valid;

  // Stimulus table. Beat 0 sits in the low word.
  string       e_name [max_entries];
  logic        e_write [max_entries];
  logic [1:0]  e_bank [max_entries];
  logic [12:0] e_row [max_entries];
  logic [8:0]  e_col [max_entries];
  logic [3:0][15:0] e_data [max_entries];
  logic [3:0][1:0]  e_mask [max_entries];
  int          n_entries = 0;

  sdram_pkg::data_t ref_mem [2**(2 + row_bits + col_bits)];
  int               cycle_count = 0;
  int               timeout_cycles;

  sdram_subsys #(
    .burst_code  (burst_code),
    .cas_latency (cas_latency),
    .trcd_cycles (trcd_cycles),
    .init_cycles (init_cycles),
    .row_bits    (row_bits),
    .col_bits    (col_bits)
  ) DUT (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_write   (req_write),
    .req_bank    (req_bank),
    .req_row     (req_row),
    .req_col     (req_col),
    .wdata       (wdata),
    .wmask       (wmask),
    .ready       (ready),
    .busy        (busy),
    .wdata_take  (wdata_take),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      abort_run($sformatf("Run did not finish within %0d cycles", timeout_cycles));
    end
  end

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(string name, sdram_pkg::data_t exp, sdram_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_state(string name, sdram_pkg::ctrl_state_t exp,
                             sdram_pkg::ctrl_state_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_cmd(string name, sdram_pkg::sdram_cmd_t exp, sdram_pkg::sdram_cmd_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
  endtask

  // Set mask bits keep the old byte.
  function automatic sdram_pkg::data_t merge_word(sdram_pkg::data_t old_word,
                                                  sdram_pkg::data_t new_word,
                                                  sdram_pkg::mask_t mask);
    sdram_pkg::data_t keep;
    keep = {{8{mask[1]}}, {8{mask[0]}}};
    return (old_word & keep) | (new_word & ~keep);
  endfunction

  // Columns wrap inside the model's column range.
  function automatic int unsigned mem_index(logic [1:0] bank, logic [12:0] row,
                                            logic [8:0] col, int beat);
    logic [col_bits-1:0] c;
    c = col[col_bits-1:0] + col_bits'(beat);
    return {bank, row[row_bits-1:0], c};
  endfunction

  task automatic add_entry(string name, logic wr, logic [1:0] bank, logic [12:0] row,
                           logic [8:0] col, logic [3:0][15:0] words, logic [3:0][1:0] masks);
    e_name[n_entries]  = name;
    e_write[n_entries] = wr;
    e_bank[n_entries]  = bank;
    e_row[n_entries]   = row;
    e_col[n_entries]   = col;
    e_data[n_entries]  = words;
    e_mask[n_entries]  = masks;
    n_entries++;
  endtask

  task automatic build_table();
    logic [3:0][15:0] w;
    logic [12:0]      row;
    logic [8:0]       col;
    add_entry("wr_guard", 1'b1, 2'd0, 13'd0, 9'd0, 64'h1234_5678_9abc_def0, 8'h00);
    for (int b = 0; b < 4; b++) begin
      for (int k = 0; k < 4; k++) begin
        w[k] = 16'ha000 | 16'(b << 8) | 16'(k * 17);
      end
      add_entry($sformatf("wr_bank%0d", b), 1'b1, 2'(b), 13'(2 + b), 9'd8, w, 8'h00);
      add_entry($sformatf("rd_bank%0d", b), 1'b0, 2'(b), 13'(2 + b), 9'd8, '0, 8'h00);
    end
    // Masks 01, 10, 11, 00 over words written by wr_bank1.
    add_entry("wr_mask", 1'b1, 2'd1, 13'd3, 9'd8, 64'h5a5a_c3c3_0ff0_7e7e, 8'b00_11_10_01);
    add_entry("rd_mask", 1'b0, 2'd1, 13'd3, 9'd8, '0, 8'h00);
    for (int r = 0; r < 3; r++) begin
      row = 13'($urandom % 16);
      col = 9'($urandom % 32);
      for (int k = 0; k < 4; k++) begin
        w[k] = 16'($urandom);
      end
      add_entry($sformatf("rnd_wr%0d", r), 1'b1, 2'(r + 1), row, col, w, 8'h00);
      for (int k = 0; k < 4; k++) begin
        w[k] = 16'($urandom);
      end
      add_entry($sformatf("rnd_mask%0d", r), 1'b1, 2'(r + 1), row, col, w, 8'($urandom));
      add_entry($sformatf("rnd_rd%0d", r), 1'b0, 2'(r + 1), row, col, '0, 8'h00);
    end
    add_entry("rd_guard", 1'b0, 2'd0, 13'd0, 9'd0, '0, 8'h00);
  endtask

  task automatic run_entry(int i);
    int  c;
    int  takes;
    int  valids;
    int  first_c;
    int  last_c;
    int  idx;
    bit  done;
    c       = 0;
    takes   = 0;
    valids  = 0;
    first_c = 0;
    last_c  = 0;
    done    = 1'b0;
    req       = 1'b1;
    req_write = e_write[i];
    req_bank  = e_bank[i];
    req_row   = e_row[i];
    req_col   = e_col[i];
    while (!done) begin
      @(posedge clk);
      #1;
      c++;
      if (c == 1) begin
        check_flag({e_name[i], " busy"}, 1'b1, busy);
        check_cmd({e_name[i], " activate"}, sdram_pkg::cmd_active, DUT.cmd);
        // Second request while busy, aimed at the guard word.
        req_write = 1'b1;
        req_bank  = 2'd0;
        req_row   = 13'd0;
        req_col   = 9'd0;
      end else if (c == 2) begin
        req = 1'b0;
      end
      if (c == 2 + trcd_cycles) begin
        check_cmd({e_name[i], " burst command"},
                  e_write[i] ? sdram_pkg::cmd_write : sdram_pkg::cmd_read, DUT.cmd);
      end
      if (wdata_take) begin
        if (takes < beats) begin
          wdata = e_data[i][takes];
          wmask = e_mask[i][takes];
          idx = mem_index(e_bank[i], e_row[i], e_col[i], takes);
          ref_mem[idx] = merge_word(ref_mem[idx], wdata, wmask);
        end
        if (takes == 0) begin
          first_c = c;
        end
        last_c = c;
        takes++;
      end
      if (rdata_valid) begin
        if (valids < beats) begin
          check_data($sformatf("%s beat %0d", e_name[i], valids),
                     ref_mem[mem_index(e_bank[i], e_row[i], e_col[i], valids)], rdata);
        end
        if (valids == 0) begin
          first_c = c;
        end
        last_c = c;
        valids++;
      end
      if (c > 1 && !busy) begin
        done = 1'b1;
      end
    end
    check_count({e_name[i], " take pulses"}, e_write[i] ? beats : 0, takes);
    check_count({e_name[i], " valid pulses"}, e_write[i] ? 0 : beats, valids);
    check_count({e_name[i], " first pulse cycle"},
                e_write[i] ? 1 + trcd_cycles : 3 + trcd_cycles + cas_latency, first_c);
    check_count({e_name[i], " burst span"}, beats - 1, last_c - first_c);
    // A write's last beat is on dq one cycle after its last take.
    check_count({e_name[i], " busy fall"}, e_write[i] ? 2 : 1, c - last_c);
    check_state({e_name[i], " end state"}, sdram_pkg::st_idle, DUT.u_fsm.state);
  endtask

  initial begin
    sdram_pkg::sdram_cmd_t prev_cmd;
    void'($urandom(32'hb0a));
    clk       = 1'b0;
    reset     = 1'b1;
    req       = 1'b0;
    req_write = 1'b0;
    req_bank  = 2'd0;
    req_row   = 13'd0;
    req_col   = 9'd0;
    wdata     = '0;
    wmask     = '0;
    build_table();
    timeout_cycles = 2 * (reset_cycles + init_cycles + 12 + n_entries * entry_cycles);

    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    check_flag("reset ready", 1'b0, ready);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset take", 1'b0, wdata_take);
    check_flag("reset valid", 1'b0, rdata_valid);
    check_cmd("reset command", sdram_pkg::cmd_nop, DUT.cmd);

    prev_cmd = DUT.cmd;
    while (!ready) begin
      prev_cmd = DUT.cmd;
      @(posedge clk);
      #1;
    end
    check_cmd("init mode load", sdram_pkg::cmd_load_mode, prev_cmd);
    check_flag("init busy", 1'b0, busy);
    check_state("init state", sdram_pkg::st_idle, DUT.u_fsm.state);

    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end

    repeat (8) begin
      @(posedge clk);
      #1;
      check_flag("idle take", 1'b0, wdata_take);
      check_flag("idle valid", 1'b0, rdata_valid);
      check_flag("idle busy", 1'b0, busy);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- project.f
hdl/sdram_pkg.sv
hdl/sdram_timer.sv
hdl/sdram_wr_path.sv
hdl/sdram_rd_capture.sv
hdl/sdram_model.sv
hdl/sdram_cmd_fsm.sv
hdl/sdram_subsys.sv
sim/tb_sdram_subsys.sv

//--- Bender.yml
package:
  name: sdram_subsys

sources:
  - hdl/sdram_pkg.sv
  - hdl/sdram_timer.sv
  - hdl/sdram_wr_path.sv
  - hdl/sdram_rd_capture.sv
  - hdl/sdram_model.sv
  - hdl/sdram_cmd_fsm.sv
  - hdl/sdram_subsys.sv
  - target: simulation
    files:
      - sim/tb_sdram_subsys.sv
